// ==== src/xma_consts.svh ====
`ifndef XMA_CONSTS_SVH
`define XMA_CONSTS_SVH

// DAC channels
`define XMA_NCHAN 4

// Complex samples per channel per clock
`define XMA_LANES 2

// Neighbour window, diagonal at the centre
`define XMA_NWIN 3

// Clocks from sample_valid in to sum_valid out
`define XMA_LATENCY 5

// Wishbone word address width
`define XMA_AW 5

// Write-only commit register, just past the 4x4 coefficient block
`define XMA_COMMIT_ADDR 16

`endif

// ==== src/xma_pkg.sv ====
`default_nettype none
`include "xma_consts.svh"

package xma_pkg;

	// Q1.15
	typedef logic signed [15:0] sample_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} coef_cplx_t;

	// Bus word on the Wishbone side, complex pair on the datapath side
	typedef union packed {
		logic [31:0] raw;
		coef_cplx_t cplx;
	} coef_word_u;

	// All real or all imaginary parts of one clock
	typedef sample_t [`XMA_NCHAN-1:0][`XMA_LANES-1:0] chan_bus_t;

	// Indexed [row m][column n]
	typedef coef_word_u [`XMA_NCHAN-1:0][`XMA_NCHAN-1:0] coef_mat_t;

endpackage

`default_nettype wire

// ==== src/cmultiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmultiplier (
	input  wire                   clk,
	input  wire xma_pkg::sample_t xr,
	input  wire xma_pkg::sample_t xi,
	input  wire xma_pkg::sample_t yr,
	input  wire xma_pkg::sample_t yi,
	output logic signed [32:0]    zr,
	output logic signed [32:0]    zi
);

	logic signed [31:0] p_rr;
	logic signed [31:0] p_ii;
	logic signed [31:0] p_ri;
	logic signed [31:0] p_ir;

	// Partial products
	always_ff @(posedge clk) begin
		p_rr <= xr * yr;
		p_ii <= xi * yi;
		p_ri <= xr * yi;
		p_ir <= xi * yr;
	end

	// One extra bit so that -1 * -1 terms cannot overflow
	always_ff @(posedge clk) begin
		zr <= p_rr - p_ii;
		zi <= p_ri + p_ir;
	end

endmodule

`default_nettype wire

// ==== src/coef_bank.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "xma_consts.svh"

module coef_bank (
	input  wire                xmaif,
	input  wire                rst,
	input  wire                wb_cyc,
	input  wire                wb_stb,
	input  wire                wb_we,
	input  wire [`XMA_AW-1:0]  wb_adr,
	input  wire [31:0]         wb_dat_w,
	output logic [31:0]        wb_dat_r,
	output logic               wb_ack,
	output xma_pkg::coef_mat_t coef_active
);

	localparam int CW = $clog2(`XMA_NCHAN);
	localparam int NWORD = `XMA_NCHAN * `XMA_NCHAN;

	xma_pkg::coef_mat_t staging;
	logic               req;
	logic               in_mat;
	logic               is_commit;
	logic [CW-1:0]      row;
	logic [CW-1:0]      col;

	// New cycle seen, not yet acked
	assign req = wb_cyc & wb_stb & ~wb_ack;

	assign in_mat = int'(wb_adr) < NWORD;
	assign is_commit = int'(wb_adr) == `XMA_COMMIT_ADDR;

	// Address m*NCHAN+n
	assign row = wb_adr[2*CW-1:CW];
	assign col = wb_adr[CW-1:0];

	always_ff @(posedge xmaif) begin
		if (rst) begin
			wb_ack <= 1'b0;
			staging <= '0;
			coef_active <= '0;
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin
				if (in_mat) begin
					staging[row][col].raw <= wb_dat_w;
				end
				// Whole matrix moves in one clock
				if (is_commit) begin
					coef_active <= staging;
				end
			end
		end
	end

	// Host holds adr until ack, so the mux can stay combinational
	always_comb begin
		wb_dat_r = '0;
		if (in_mat) begin
			wb_dat_r = staging[row][col].raw;
		end
	end

endmodule

`default_nettype wire

// ==== src/xmultadd.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "xma_consts.svh"

module xmultadd (
	input  wire                     xmaif,
	input  wire                     rst,
	input  wire xma_pkg::coef_mat_t coef,
	input  wire                     sample_valid,
	input  wire xma_pkg::chan_bus_t dac_re,
	input  wire xma_pkg::chan_bus_t dac_im,
	output logic                    sum_valid,
	output xma_pkg::chan_bus_t      sum_re,
	output xma_pkg::chan_bus_t      sum_im
);

	localparam int NCH = `XMA_NCHAN;
	localparam int NL = `XMA_LANES;
	localparam int NW = `XMA_NWIN;
	localparam int HALF = NW / 2;
	localparam int LAT = `XMA_LATENCY;

	xma_pkg::coef_mat_t coef_r;
	xma_pkg::chan_bus_t in_re;
	xma_pkg::chan_bus_t in_im;
	xma_pkg::sample_t   term_re [NCH][NL][NW];
	xma_pkg::sample_t   term_im [NCH][NL][NW];
	xma_pkg::chan_bus_t nxt_re;
	xma_pkg::chan_bus_t nxt_im;
	logic [LAT-1:0]     vpipe;

	// Stage 1, samples and coefficients together
	always_ff @(posedge xmaif) begin
		coef_r <= coef;
		in_re <= dac_re;
		in_im <= dac_im;
	end

	for (genvar m = 0; m < NCH; m++) begin : g_row
		for (genvar l = 0; l < NL; l++) begin : g_lane
			for (genvar w = 0; w < NW; w++) begin : g_win
				// Column of this window position, wrapping around the channels
				localparam int N = (m + w - HALF + NCH) % NCH;

				if (w == HALF) begin : g_diag
					xma_pkg::sample_t dly_re [LAT-2];
					xma_pkg::sample_t dly_im [LAT-2];

					// Unity tap, delayed to meet the products at the sum
					always_ff @(posedge xmaif) begin
						dly_re[0] <= dac_re[m][l];
						dly_im[0] <= dac_im[m][l];
						for (int i = 1; i < LAT-2; i++) begin
							dly_re[i] <= dly_re[i-1];
							dly_im[i] <= dly_im[i-1];
						end
						term_re[m][l][w] <= dly_re[LAT-3];
						term_im[m][l][w] <= dly_im[LAT-3];
					end
				end else begin : g_tap
					logic signed [32:0] zr;
					logic signed [32:0] zi;

					cmultiplier u_mult (
						.clk (xmaif),
						.xr  (coef_r[m][N].cplx.re),
						.xi  (coef_r[m][N].cplx.im),
						.yr  (in_re[N][l]),
						.yi  (in_im[N][l]),
						.zr  (zr),
						.zi  (zi)
					);

					// Back to Q1.15, truncated
					always_ff @(posedge xmaif) begin
						term_re[m][l][w] <= zr[30:15];
						term_im[m][l][w] <= zi[30:15];
					end
				end
			end
		end
	end

	// Window sum, wraps at 16 bits
	always_comb begin
		for (int m = 0; m < NCH; m++) begin
			for (int l = 0; l < NL; l++) begin
				nxt_re[m][l] = '0;
				nxt_im[m][l] = '0;
				for (int w = 0; w < NW; w++) begin
					nxt_re[m][l] = nxt_re[m][l] + term_re[m][l][w];
					nxt_im[m][l] = nxt_im[m][l] + term_im[m][l][w];
				end
			end
		end
	end

	always_ff @(posedge xmaif) begin
		sum_re <= nxt_re;
		sum_im <= nxt_im;
	end

	// Valid only rides along
	always_ff @(posedge xmaif) begin
		if (rst) begin
			vpipe <= '0;
		end else begin
			vpipe <= {vpipe[LAT-2:0], sample_valid};
		end
	end

	assign sum_valid = vpipe[LAT-1];

endmodule

`default_nettype wire

// ==== src/xma_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "xma_consts.svh"

module xma_top (
	input  wire                     xmaif,
	input  wire                     rst,
	input  wire                     wb_cyc,
	input  wire                     wb_stb,
	input  wire                     wb_we,
	input  wire [`XMA_AW-1:0]       wb_adr,
	input  wire [31:0]              wb_dat_w,
	output wire [31:0]              wb_dat_r,
	output wire                     wb_ack,
	input  wire                     sample_valid,
	input  wire xma_pkg::chan_bus_t dac_re,
	input  wire xma_pkg::chan_bus_t dac_im,
	output wire                     sum_valid,
	output wire xma_pkg::chan_bus_t sum_re,
	output wire xma_pkg::chan_bus_t sum_im
);

	wire xma_pkg::coef_mat_t coef_active;

	coef_bank u_bank (
		.xmaif       (xmaif),
		.rst         (rst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.coef_active (coef_active)
	);

	xmultadd u_xma (
		.xmaif        (xmaif),
		.rst          (rst),
		.coef         (coef_active),
		.sample_valid (sample_valid),
		.dac_re       (dac_re),
		.dac_im       (dac_im),
		.sum_valid    (sum_valid),
		.sum_re       (sum_re),
		.sum_im       (sum_im)
	);

endmodule

`default_nettype wire

// ==== tb/xma_checker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "xma_consts.svh"

module xma_checker (
	input wire xmaif,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire sample_valid,
	input wire sum_valid
);

	// Classic ack is a single clock pulse
	a_ack_one: assert property (@(posedge xmaif) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for more than one clock");

	a_ack_req: assert property (@(posedge xmaif) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without cyc and stb on the clock before");

	// Valid only rides along the pipeline
	a_valid_lat: assert property (@(posedge xmaif) disable iff (rst)
		sum_valid == $past(sample_valid, `XMA_LATENCY))
		else $error("sum_valid does not follow sample_valid by the pipeline latency");

	a_rst_quiet: assert property (@(posedge xmaif)
		rst |=> (!wb_ack && !sum_valid))
		else $error("wb_ack or sum_valid high during reset");

endmodule

bind xma_top xma_checker u_checker (
	.xmaif        (xmaif),
	.rst          (rst),
	.wb_cyc       (wb_cyc),
	.wb_stb       (wb_stb),
	.wb_ack       (wb_ack),
	.sample_valid (sample_valid),
	.sum_valid    (sum_valid)
);

`default_nettype wire

// ==== tb/xma_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "xma_consts.svh"

module xma_tb;

	logic               xmaif;
	logic               rst;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	logic [`XMA_AW-1:0] wb_adr;
	logic [31:0]        wb_dat_w;
	logic [31:0]        wb_dat_r;
	logic               wb_ack;
	logic               sample_valid;
	xma_pkg::chan_bus_t dac_re;
	xma_pkg::chan_bus_t dac_im;
	logic               sum_valid;
	xma_pkg::chan_bus_t sum_re;
	xma_pkg::chan_bus_t sum_im;

	xma_pkg::coef_mat_t model_staging;
	xma_pkg::coef_mat_t model_active;
	xma_pkg::chan_bus_t exp_re_q[$];
	xma_pkg::chan_bus_t exp_im_q[$];
	logic               exp_v_q[$];
	logic               mon_on = 1'b0;
	logic [31:0]        lcg_state = 32'd12860;

	xma_top uut (
		.xmaif        (xmaif),
		.rst          (rst),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.sample_valid (sample_valid),
		.dac_re       (dac_re),
		.dac_im       (dac_im),
		.sum_valid    (sum_valid),
		.sum_re       (sum_re),
		.sum_im       (sum_im)
	);

	initial begin
		xmaif = 1'b0;
		forever #10 xmaif = ~xmaif;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Full scale extremes one time in eight
	function automatic xma_pkg::sample_t rand_sample();
		logic [31:0] r;
		r = next_rand();
		if (r[2:0] == 3'd0) begin
			return r[3] ? 16'sh7fff : 16'sh8000;
		end else begin
			return r[31:16];
		end
	endfunction

	// Diagonal passes, neighbours are Q1.15 products shifted by 15, all sums wrap
	function automatic void expected_sums(input xma_pkg::coef_mat_t c,
		input xma_pkg::chan_bus_t xr, input xma_pkg::chan_bus_t xi,
		output xma_pkg::chan_bus_t yr, output xma_pkg::chan_bus_t yi);
		longint pr;
		longint pi;
		int n;
		yr = xr;
		yi = xi;
		for (int m = 0; m < `XMA_NCHAN; m++) begin
			for (int l = 0; l < `XMA_LANES; l++) begin
				for (int d = -1; d <= 1; d += 2) begin
					n = (m + d + `XMA_NCHAN) % `XMA_NCHAN;
					pr = longint'(c[m][n].cplx.re) * longint'(xr[n][l])
						- longint'(c[m][n].cplx.im) * longint'(xi[n][l]);
					pi = longint'(c[m][n].cplx.re) * longint'(xi[n][l])
						+ longint'(c[m][n].cplx.im) * longint'(xr[n][l]);
					yr[m][l] = yr[m][l] + xma_pkg::sample_t'(pr >>> 15);
					yi[m][l] = yi[m][l] + xma_pkg::sample_t'(pi >>> 15);
				end
			end
		end
	endfunction

	task automatic check_sample(input xma_pkg::sample_t got, input xma_pkg::sample_t exp,
		input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "sample mismatch");
		end
	endtask

	task automatic check_word(input xma_pkg::coef_word_u got, input xma_pkg::coef_word_u exp,
		input string what);
		if (got.raw !== exp.raw) begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got.raw, exp.raw);
			$display("** FAIL **");
			$fatal(1, "register mismatch");
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Output at this edge belongs to the input driven LATENCY edges earlier
	always @(posedge xmaif) begin : monitor
		xma_pkg::chan_bus_t e_re;
		xma_pkg::chan_bus_t e_im;
		logic               e_v;
		#1;
		if (mon_on) begin
			expected_sums(model_active, dac_re, dac_im, e_re, e_im);
			exp_re_q.push_back(e_re);
			exp_im_q.push_back(e_im);
			exp_v_q.push_back(sample_valid);
			if (exp_v_q.size() >= `XMA_LATENCY) begin
				e_re = exp_re_q.pop_front();
				e_im = exp_im_q.pop_front();
				e_v = exp_v_q.pop_front();
				check_flag(sum_valid, e_v, "sum_valid");
				for (int m = 0; m < `XMA_NCHAN; m++) begin
					for (int l = 0; l < `XMA_LANES; l++) begin
						if (e_v) begin
							check_sample(sum_re[m][l], e_re[m][l],
								$sformatf("sum_re[%0d][%0d]", m, l));
							check_sample(sum_im[m][l], e_im[m][l],
								$sformatf("sum_im[%0d][%0d]", m, l));
						end
					end
				end
			end else if (sum_valid) begin
				$display("A valid output arrived with no sample queued for it");
				$display("** FAIL **");
				$fatal(1, "unexpected sum_valid");
			end
		end
	end

	task automatic wb_xfer(input logic we, input int adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr[`XMA_AW-1:0];
		wb_dat_w = wdat;
		waited = 0;
		do begin
			@(posedge xmaif);
			#2;
			waited++;
		end while (!wb_ack && waited < 10);
		if (!wb_ack) begin
			$display("No Wishbone ack within 10 clocks at address %0d", adr);
			$display("** FAIL **");
			$fatal(1, "Wishbone timeout");
		end else begin
			rdat = wb_dat_r;
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we = 1'b0;
		end
	endtask

	task automatic wb_write(input int adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_xfer(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input int adr, output logic [31:0] data);
		wb_xfer(1'b0, adr, 32'h0, data);
	endtask

	task automatic set_coef(input int m, input int n, input logic [31:0] w);
		wb_write(m * `XMA_NCHAN + n, w);
		model_staging[m][n].raw = w;
	endtask

	task automatic commit_coefs();
		wb_write(`XMA_COMMIT_ADDR, 32'h0);
		model_active = model_staging;
	endtask

	task automatic verify_staging();
		logic [31:0] rd;
		for (int m = 0; m < `XMA_NCHAN; m++) begin
			for (int n = 0; n < `XMA_NCHAN; n++) begin
				wb_read(m * `XMA_NCHAN + n, rd);
				check_word(rd, model_staging[m][n], $sformatf("staging[%0d][%0d]", m, n));
			end
		end
	endtask

	task automatic drive_stream(input int cycles, input logic rand_valid);
		logic [31:0] r;
		repeat (cycles) begin
			@(posedge xmaif);
			#2;
			for (int m = 0; m < `XMA_NCHAN; m++) begin
				for (int l = 0; l < `XMA_LANES; l++) begin
					dac_re[m][l] = rand_sample();
					dac_im[m][l] = rand_sample();
				end
			end
			r = next_rand();
			sample_valid = rand_valid ? r[20] : 1'b1;
		end
	endtask

	task automatic reset_state();
		verify_staging();
		drive_stream(20, 1'b0);
		drive_stream(10, 1'b1);
	endtask

	task automatic register_readback();
		logic [31:0] rd;
		for (int m = 0; m < `XMA_NCHAN; m++) begin
			for (int n = 0; n < `XMA_NCHAN; n++) begin
				set_coef(m, n, next_rand());
			end
		end
		verify_staging();
		wb_write(`XMA_COMMIT_ADDR + 1, next_rand());
		verify_staging();
		wb_read(`XMA_COMMIT_ADDR, rd);
		check_word(rd, 32'h0, "commit register read");
	endtask

	task automatic staging_isolation();
		drive_stream(8, 1'b0);
		for (int m = 0; m < `XMA_NCHAN; m++) begin
			set_coef(m, (m + 1) % `XMA_NCHAN, {rand_sample(), rand_sample()});
			set_coef(m, (m + 3) % `XMA_NCHAN, {rand_sample(), rand_sample()});
		end
		drive_stream(8, 1'b0);
		commit_coefs();
		drive_stream(12, 1'b0);
	endtask

	task automatic known_products();
		for (int m = 0; m < `XMA_NCHAN; m++) begin
			set_coef(m, (m + 1) % `XMA_NCHAN, 32'h4000_0000);
			set_coef(m, (m + 3) % `XMA_NCHAN, 32'h4000_0000);
			set_coef(m, (m + 2) % `XMA_NCHAN, 32'h7fff_7fff);
		end
		// -j on row 1 from channel 0
		set_coef(1, 0, 32'h0000_8000);
		commit_coefs();
		@(posedge xmaif);
		#2;
		dac_re = '0;
		dac_im = '0;
		sample_valid = 1'b1;
		for (int l = 0; l < `XMA_LANES; l++) begin
			dac_re[0][l] = 16'sh4000;
		end
		repeat (`XMA_LATENCY) @(posedge xmaif);
		#1;
		for (int l = 0; l < `XMA_LANES; l++) begin
			check_sample(sum_re[0][l], 16'sh4000, "diagonal pass of 0.5");
			check_sample(sum_re[3][l], 16'sh2000, "0.5 tap on 0.5");
			check_sample(sum_im[3][l], 16'sh0000, "0.5 tap imaginary");
			check_sample(sum_re[1][l], 16'sh0000, "rotated real");
			check_sample(sum_im[1][l], -16'sh4000, "rotated imaginary");
			check_sample(sum_re[2][l], 16'sh0000, "out of window real");
			check_sample(sum_im[2][l], 16'sh0000, "out of window imaginary");
		end
		#1;
	endtask

	task automatic random_run();
		for (int r = 0; r < 2; r++) begin
			for (int m = 0; m < `XMA_NCHAN; m++) begin
				set_coef(m, (m + 1) % `XMA_NCHAN, {rand_sample(), rand_sample()});
				set_coef(m, (m + 3) % `XMA_NCHAN, {rand_sample(), rand_sample()});
			end
			commit_coefs();
			drive_stream(100, 1'b1);
		end
	endtask

	initial begin
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		sample_valid = 1'b0;
		dac_re = '0;
		dac_im = '0;
		model_staging = '0;
		model_active = '0;
		repeat (4) @(posedge xmaif);
		#2;
		rst = 1'b0;
		mon_on = 1'b1;
		reset_state();
		register_readback();
		staging_isolation();
		known_products();
		random_run();
		// Flush what is still in flight
		drive_stream(`XMA_LATENCY + 2, 1'b0);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/xma_pkg.sv
src/cmultiplier.sv
src/coef_bank.sv
src/xmultadd.sv
src/xma_top.sv
tb/xma_checker.sv
tb/xma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module xma_tb -o xma_sim
./obj_dir/xma_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF '** PASS **' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
